// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = MipsCoreTb
FILELIST = tb.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "STATUS: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

// File: hdl/Alu.sv
`timescale 1ns/1ps
`default_nettype none

module Alu
    import CpuPkg::*, CtrlPkg::*;
(
    input  aluOp_t      aluOp,
    input  extMode_t    extMode,
    input  logic        aluSrc,
    input  word_t       a,
    input  word_t       b,
    input  logic [15:0] imm16,
    input  logic [4:0]  shamt,
    output word_t       result,
    output word_t       extImm
);

    word_t opB;

    always_comb begin
        case (extMode)
            EXT_SIGN:  extImm = {{16{imm16[15]}}, imm16};
            EXT_UPPER: extImm = {imm16, 16'h0000};               // lui
            default:   extImm = {16'h0000, imm16};
        endcase
    end

    assign opB = aluSrc ? extImm : b;

    // add and sub simply wrap
    always_comb begin
        case (aluOp)
            ALU_SUB: result = a - opB;
            ALU_XOR: result = a ^ opB;
            ALU_OR:  result = a | opB;
            ALU_SLL: result = opB << shamt;                      // shifts rt
            default: result = a + opB;
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/Controller.sv
`timescale 1ns/1ps
`default_nettype none

module Controller
    import CpuPkg::*, CtrlPkg::*;
(
    input  opcode_t  opcode,
    input  funct_t   funct,
    output aluOp_t   aluOp,
    output logic     memRead,
    output logic     memWrite,
    output logic     regWrite,
    output wbSel_t   wbSel,
    output extMode_t extMode,
    output logic     aluSrc,
    output dstSel_t  dstSel,
    output npcMode_t npcMode,
    output logic     isBeq,
    output logic     isBgtz
);

    //////////////////////////////
    // instruction classes, one-hot
    //////////////////////////////
    logic rType;
    logic opAdd, opSub, opXor, opSll, opJr, opJalr;
    logic opOri, opAddi, opLui, opLw, opLb, opSw;
    logic opBeq, opBgtz, opJ, opJal;

    assign rType  = (opcode == OP_RTYPE);
    assign opAdd  = rType && (funct == FN_ADD);
    assign opSub  = rType && (funct == FN_SUB);
    assign opXor  = rType && (funct == FN_XOR);
    assign opSll  = rType && (funct == FN_SLL);
    assign opJr   = rType && (funct == FN_JR);
    assign opJalr = rType && (funct == FN_JALR);
    assign opOri  = (opcode == OP_ORI);
    assign opAddi = (opcode == OP_ADDI);
    assign opLui  = (opcode == OP_LUI);
    assign opLw   = (opcode == OP_LW);
    assign opLb   = (opcode == OP_LB);
    assign opSw   = (opcode == OP_SW);
    assign opBeq  = (opcode == OP_BEQ);
    assign opBgtz = (opcode == OP_BGTZ);
    assign opJ    = (opcode == OP_J);
    assign opJal  = (opcode == OP_JAL);

    //////////////////////////////
    // control fields
    //////////////////////////////
    assign aluOp = opSub ? ALU_SUB :
                   opXor ? ALU_XOR :
                   opOri ? ALU_OR  :
                   opSll ? ALU_SLL :
                   ALU_ADD;                                      // addi, loads, stores

    assign memRead  = opLw | opLb;
    assign memWrite = opSw;
    assign regWrite = opAdd | opSub | opXor | opSll | opJalr | opOri | opAddi
                    | opLui | opLw | opLb | opJal;

    assign wbSel = opLw           ? WB_MEMWORD :
                   opLui          ? WB_LUI     :
                   (opJal|opJalr) ? WB_LINK    :
                   opLb           ? WB_MEMBYTE :
                   WB_ALU;

    assign extMode = (opAddi | opLw | opLb | opSw | opBeq | opBgtz) ? EXT_SIGN :
                     opLui ? EXT_UPPER :
                     EXT_ZERO;                                   // ori

    assign aluSrc = opOri | opAddi | opLui | opLw | opLb | opSw;

    assign dstSel = (opAdd | opSub | opXor | opSll | opJalr) ? DST_RD :
                    opJal ? DST_RA :
                    DST_RT;

    assign npcMode = (opBeq | opBgtz) ? NPC_BRANCH :
                     (opJ | opJal)    ? NPC_JUMP   :
                     (opJr | opJalr)  ? NPC_REG    :
                     NPC_SEQ;                                    // also unknown encodings

    assign isBeq  = opBeq;
    assign isBgtz = opBgtz;

endmodule

`default_nettype wire

// File: hdl/CpuPkg.sv
`default_nettype none

package CpuPkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] regIdx_t;

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        OP_RTYPE = 6'b000000,
        OP_J     = 6'b000010,
        OP_JAL   = 6'b000011,
        OP_BEQ   = 6'b000100,
        OP_BGTZ  = 6'b000111,
        OP_ADDI  = 6'b001000,
        OP_ORI   = 6'b001101,
        OP_LUI   = 6'b001111,
        OP_LB    = 6'b100000,
        OP_LW    = 6'b100011,
        OP_SW    = 6'b101011
    } opcode_t;

    // function field of R-type, instr[5:0]
    typedef enum logic [5:0] {
        FN_SLL  = 6'b000000,
        FN_JR   = 6'b001000,
        FN_JALR = 6'b001001,
        FN_ADD  = 6'b100000,
        FN_SUB  = 6'b100010,
        FN_XOR  = 6'b100110
    } funct_t;

    localparam word_t resetPc = 32'h0000_3000;
    localparam int dmemWords = 256;           // 1 KiB of words
    localparam regIdx_t linkReg = 5'd31;      // $ra

endpackage

`default_nettype wire

// File: hdl/CtrlPkg.sv
`default_nettype none

package CtrlPkg;

    typedef enum logic [2:0] {
        ALU_ADD = 3'b000,
        ALU_SUB = 3'b001,
        ALU_XOR = 3'b010,
        ALU_OR  = 3'b011,
        ALU_SLL = 3'b100
    } aluOp_t;

    typedef enum logic [2:0] {
        WB_ALU     = 3'b000,
        WB_MEMWORD = 3'b001,
        WB_LUI     = 3'b010,
        WB_LINK    = 3'b011,
        WB_MEMBYTE = 3'b100
    } wbSel_t;

    typedef enum logic [2:0] {
        EXT_ZERO  = 3'b000,
        EXT_SIGN  = 3'b001,
        EXT_UPPER = 3'b010
    } extMode_t;

    typedef enum logic [1:0] {
        DST_RT = 2'b00,
        DST_RD = 2'b01,
        DST_RA = 2'b10
    } dstSel_t;

    typedef enum logic [2:0] {
        NPC_SEQ    = 3'b000,
        NPC_BRANCH = 3'b001,
        NPC_JUMP   = 3'b010,
        NPC_REG    = 3'b100
    } npcMode_t;

endpackage

`default_nettype wire

// File: hdl/DataMem.sv
`timescale 1ns/1ps
`default_nettype none

module DataMem
    import CpuPkg::*;
(
    input  logic  clk,
    input  logic  we,
    input  word_t addr,
    input  word_t wdata,
    output word_t rdWord,
    output word_t rdByte
);

    localparam int idxBits = $clog2(dmemWords);

    word_t mem [dmemWords];
    logic [idxBits-1:0] wordIdx;

    assign wordIdx = addr[idxBits+1:2];                          // word address
    assign rdWord  = mem[wordIdx];

    // little-endian lane, zero-extended
    always_comb begin
        case (addr[1:0])
            2'd0:    rdByte = {24'h0, rdWord[7:0]};
            2'd1:    rdByte = {24'h0, rdWord[15:8]};
            2'd2:    rdByte = {24'h0, rdWord[23:16]};
            default: rdByte = {24'h0, rdWord[31:24]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wordIdx] <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: hdl/MipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module MipsCore
    import CpuPkg::*, CtrlPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  word_t   instr,
    output word_t   pc,
    output logic    wbEn,
    output regIdx_t wbReg,
    output word_t   wbData
);

    //////////////////////////////
    // instruction fields
    //////////////////////////////
    opcode_t     opcode;
    funct_t      funct;
    regIdx_t     rs, rt, rd;
    logic [4:0]  shamt;
    logic [15:0] imm16;
    logic [25:0] jumpIndex;

    assign opcode    = opcode_t'(instr[31:26]);
    assign funct     = funct_t'(instr[5:0]);
    assign rs        = instr[25:21];
    assign rt        = instr[20:16];
    assign rd        = instr[15:11];
    assign shamt     = instr[10:6];
    assign imm16     = instr[15:0];
    assign jumpIndex = instr[25:0];

    aluOp_t   aluOp;
    wbSel_t   wbSel;
    extMode_t extMode;
    dstSel_t  dstSel;
    npcMode_t npcMode;
    logic     memRead, memWrite, regWrite, aluSrc, isBeq, isBgtz;
    logic     memWriteEn;
    word_t    rsData, rtData, aluResult, extImm, pcPlus4;
    word_t    rdWord, rdByte, loadWord, loadByte;

    Controller ctrl_i (
        .opcode(opcode), .funct(funct), .aluOp(aluOp), .memRead(memRead),
        .memWrite(memWrite), .regWrite(regWrite), .wbSel(wbSel), .extMode(extMode),
        .aluSrc(aluSrc), .dstSel(dstSel), .npcMode(npcMode), .isBeq(isBeq),
        .isBgtz(isBgtz)
    );

    PcUnit pc_i (
        .clk(clk), .rst(rst), .npcMode(npcMode), .isBeq(isBeq), .isBgtz(isBgtz),
        .rsData(rsData), .rtData(rtData), .extImm(extImm), .jumpIndex(jumpIndex),
        .pc(pc), .pcPlus4(pcPlus4)
    );

    RegFile rf_i (
        .clk(clk), .rst(rst), .rs(rs), .rt(rt), .we(wbEn), .wd(wbReg),
        .wdata(wbData), .rsData(rsData), .rtData(rtData)
    );

    Alu alu_i (
        .aluOp(aluOp), .extMode(extMode), .aluSrc(aluSrc), .a(rsData), .b(rtData),
        .imm16(imm16), .shamt(shamt), .result(aluResult), .extImm(extImm)
    );

    DataMem dmem_i (
        .clk(clk), .we(memWriteEn), .addr(aluResult), .wdata(rtData),
        .rdWord(rdWord), .rdByte(rdByte)
    );

    //////////////////////////////
    // write-back
    //////////////////////////////
    assign memWriteEn = memWrite & ~rst;
    assign loadWord   = memRead ? rdWord : '0;                   // quiet outside loads
    assign loadByte   = memRead ? rdByte : '0;

    always_comb begin
        case (dstSel)
            DST_RD:  wbReg = rd;
            DST_RA:  wbReg = linkReg;
            default: wbReg = rt;
        endcase
    end

    always_comb begin
        case (wbSel)
            WB_MEMWORD: wbData = loadWord;
            WB_LUI:     wbData = extImm;
            WB_LINK:    wbData = pcPlus4;
            WB_MEMBYTE: wbData = loadByte;
            default:    wbData = aluResult;
        endcase
    end

    // a write to $zero never commits, so it is not reported
    assign wbEn = regWrite & ~rst & (wbReg != '0);

endmodule

`default_nettype wire

// File: hdl/PcUnit.sv
`timescale 1ns/1ps
`default_nettype none

module PcUnit
    import CpuPkg::*, CtrlPkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  npcMode_t    npcMode,
    input  logic        isBeq,
    input  logic        isBgtz,
    input  word_t       rsData,
    input  word_t       rtData,
    input  word_t       extImm,
    input  logic [25:0] jumpIndex,
    output word_t       pc,
    output word_t       pcPlus4
);

    logic  taken;
    word_t branchTarget;
    word_t jumpTarget;
    word_t nextPc;

    assign pcPlus4 = pc + 32'd4;

    // condition only matters in branch mode
    assign taken = (isBeq && (rsData == rtData))
                 | (isBgtz && ($signed(rsData) > 0));

    assign branchTarget = pcPlus4 + {extImm[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], jumpIndex, 2'b00};

    always_comb begin
        case (npcMode)
            NPC_BRANCH: nextPc = taken ? branchTarget : pcPlus4;
            NPC_JUMP:   nextPc = jumpTarget;
            NPC_REG:    nextPc = rsData;                         // jr, jalr
            default:    nextPc = pcPlus4;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

`default_nettype wire

// File: hdl/RegFile.sv
`timescale 1ns/1ps
`default_nettype none

module RegFile
    import CpuPkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  regIdx_t rs,
    input  regIdx_t rt,
    input  logic    we,
    input  regIdx_t wd,
    input  word_t   wdata,
    output word_t   rsData,
    output word_t   rtData
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wd != '0)) begin                     // $zero stays zero
            regs[wd] <= wdata;
        end
    end

    assign rsData = (rs == '0) ? '0 : regs[rs];
    assign rtData = (rt == '0) ? '0 : regs[rt];

endmodule

`default_nettype wire

// File: tb.f
hdl/CpuPkg.sv
hdl/CtrlPkg.sv
hdl/Controller.sv
hdl/PcUnit.sv
hdl/RegFile.sv
hdl/Alu.sv
hdl/DataMem.sv
hdl/MipsCore.sv
verification/TbClock.sv
verification/MipsCoreAsserts.sv
verification/MipsCoreTb.sv

// File: verification/MipsCoreAsserts.sv
`timescale 1ns/1ps
`default_nettype none

module MipsCoreAsserts
    import CpuPkg::*;
(
    input logic    clk,
    input logic    rst,
    input word_t   pc,
    input logic    wbEn,
    input regIdx_t wbReg
);

    resetQuiet: assert property (@(posedge clk) rst |-> !wbEn)
        else $error("register write enabled while in reset");

    noZeroWrite: assert property (@(posedge clk) wbEn |-> (wbReg != 5'd0))
        else $error("write-back reported for register zero");

    // pc starts unknown before the first reset edge
    pcAligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("pc is not word-aligned");

endmodule

bind MipsCore MipsCoreAsserts asserts_i (
    .clk(clk), .rst(rst), .pc(pc), .wbEn(wbEn), .wbReg(wbReg)
);

`default_nettype wire

// File: verification/MipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module MipsCoreTb
    import CpuPkg::*;
();

    localparam int clkPeriod    = 40;
    localparam int resetCycles  = 16;
    localparam int marginCycles = 10;
    localparam int lcgSteps     = 12;

    logic    clk, rst, wbEn;
    word_t   instr, pc, wbData;
    regIdx_t wbReg;

    // stimulus table, one entry per executed instruction
    word_t   tabInstr[$];
    word_t   tabPc[$];
    logic    tabEn[$];
    regIdx_t tabReg[$];
    word_t   tabData[$];
    string   tabName[$];

    word_t refRegs [32];                                         // reference register model
    word_t lcgState = 32'd48197;
    logic  tableBuilt = 1'b0;
    int    stepErrors = 0;
    int    passCount = 0;
    int    failCount = 0;

    TbClock clkGen_i (.clk(clk));

    MipsCore dut_i (
        .clk(clk), .rst(rst), .instr(instr), .pc(pc),
        .wbEn(wbEn), .wbReg(wbReg), .wbData(wbData)
    );

    //////////////////////////////
    // encoding and model helpers
    //////////////////////////////
    function automatic word_t rType(regIdx_t rs, regIdx_t rt, regIdx_t rd,
                                    logic [4:0] shamt, funct_t fn);
        return {OP_RTYPE, rs, rt, rd, shamt, fn};
    endfunction

    function automatic word_t iType(opcode_t op, regIdx_t rs, regIdx_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jType(opcode_t op, logic [25:0] index);
        return {op, index};
    endfunction

    function automatic word_t signExt(logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic word_t nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    task automatic addStep(input string name, input word_t code, input word_t expPc,
                           input logic expEn, input regIdx_t expReg, input word_t expData);
        tabName.push_back(name);
        tabInstr.push_back(code);
        tabPc.push_back(expPc);
        tabEn.push_back(expEn);
        tabReg.push_back(expReg);
        tabData.push_back(expData);
        if (expEn && expReg != 5'd0) begin
            refRegs[expReg] = expData;                           // keep model in step
        end
    endtask

    task automatic buildTable();
        word_t       rnd;
        word_t       value;
        word_t       nextPc;
        logic [15:0] imm;
        regIdx_t     dst;
        regIdx_t     src;
        foreach (refRegs[i]) refRegs[i] = '0;
        // immediates and ALU
        addStep("ori",  iType(OP_ORI, 5'd0, 5'd1, 16'h8001), 32'h3000, 1'b1, 5'd1, 32'h0000_8001);
        addStep("addi", iType(OP_ADDI, 5'd0, 5'd2, 16'hFFFF), 32'h3004, 1'b1, 5'd2, 32'hFFFF_FFFF);
        addStep("lui",  iType(OP_LUI, 5'd0, 5'd3, 16'h7FFF), 32'h3008, 1'b1, 5'd3, 32'h7FFF_0000);
        addStep("add",  rType(5'd2, 5'd1, 5'd4, 5'd0, FN_ADD), 32'h300C, 1'b1, 5'd4, 32'h0000_8000);
        addStep("sub",  rType(5'd0, 5'd1, 5'd5, 5'd0, FN_SUB), 32'h3010, 1'b1, 5'd5, 32'hFFFF_7FFF);
        addStep("xor",  rType(5'd3, 5'd1, 5'd6, 5'd0, FN_XOR), 32'h3014, 1'b1, 5'd6, 32'h7FFF_8001);
        addStep("sll",  rType(5'd0, 5'd1, 5'd7, 5'd4, FN_SLL), 32'h3018, 1'b1, 5'd7, 32'h0008_0010);
        addStep("bad",  {6'h3F, 5'd1, 5'd2, 16'h1234}, 32'h301C, 1'b0, 5'd0, 32'h0);
        // memory
        addStep("ori",  iType(OP_ORI, 5'd0, 5'd8, 16'h0040), 32'h3020, 1'b1, 5'd8, 32'h0000_0040);
        addStep("lui",  iType(OP_LUI, 5'd0, 5'd9, 16'hA1B2), 32'h3024, 1'b1, 5'd9, 32'hA1B2_0000);
        addStep("ori",  iType(OP_ORI, 5'd9, 5'd9, 16'hC3D4), 32'h3028, 1'b1, 5'd9, 32'hA1B2_C3D4);
        addStep("sw",   iType(OP_SW, 5'd8, 5'd9, 16'd4), 32'h302C, 1'b0, 5'd0, 32'h0);
        addStep("lw",   iType(OP_LW, 5'd8, 5'd10, 16'd4), 32'h3030, 1'b1, 5'd10, 32'hA1B2_C3D4);
        addStep("lb0",  iType(OP_LB, 5'd8, 5'd11, 16'd4), 32'h3034, 1'b1, 5'd11, 32'h0000_00D4);
        addStep("lb1",  iType(OP_LB, 5'd8, 5'd12, 16'd5), 32'h3038, 1'b1, 5'd12, 32'h0000_00C3);
        addStep("lb2",  iType(OP_LB, 5'd8, 5'd13, 16'd6), 32'h303C, 1'b1, 5'd13, 32'h0000_00B2);
        addStep("lb3",  iType(OP_LB, 5'd8, 5'd14, 16'd7), 32'h3040, 1'b1, 5'd14, 32'h0000_00A1);
        // branches, the next entry sits at the target
        addStep("beq",  iType(OP_BEQ, 5'd9, 5'd10, 16'd2), 32'h3044, 1'b0, 5'd0, 32'h0);
        addStep("beq",  iType(OP_BEQ, 5'd1, 5'd9, 16'd5), 32'h3050, 1'b0, 5'd0, 32'h0);
        addStep("bgtz", iType(OP_BGTZ, 5'd1, 5'd0, 16'd1), 32'h3054, 1'b0, 5'd0, 32'h0);
        addStep("bgtz", iType(OP_BGTZ, 5'd2, 5'd0, 16'd3), 32'h305C, 1'b0, 5'd0, 32'h0);
        // jumps and links
        addStep("j",    jType(OP_J, 26'h0000C20), 32'h3060, 1'b0, 5'd0, 32'h0);
        addStep("jal",  jType(OP_JAL, 26'h0000C28), 32'h3080, 1'b1, 5'd31, 32'h0000_3084);
        addStep("jr",   rType(5'd31, 5'd0, 5'd0, 5'd0, FN_JR), 32'h30A0, 1'b0, 5'd0, 32'h0);
        addStep("ori",  iType(OP_ORI, 5'd0, 5'd15, 16'h30C0), 32'h3084, 1'b1, 5'd15, 32'h30C0);
        addStep("jalr", rType(5'd15, 5'd0, 5'd16, 5'd0, FN_JALR), 32'h3088, 1'b1, 5'd16,
                32'h0000_308C);
        addStep("add0", rType(5'd1, 5'd1, 5'd0, 5'd0, FN_ADD), 32'h30C0, 1'b0, 5'd0, 32'h0);
        //////////////////////////////
        // random block, checked against refRegs
        //////////////////////////////
        nextPc = 32'h30C4;
        for (int k = 0; k < lcgSteps; k++) begin
            rnd = nextRandom();
            imm = rnd[31:16];
            dst = regIdx_t'(17 + k % 8);
            src = regIdx_t'(17 + (k + 3) % 8);
            case (k % 3)
                0: begin
                    value = refRegs[src] + signExt(imm);
                    addStep("addi", iType(OP_ADDI, src, dst, imm), nextPc, 1'b1, dst, value);
                end
                1: begin
                    value = refRegs[src] | {16'h0000, imm};
                    addStep("ori", iType(OP_ORI, src, dst, imm), nextPc, 1'b1, dst, value);
                end
                default: begin
                    value = refRegs[src] ^ refRegs[9];
                    addStep("xor", rType(src, 5'd9, dst, 5'd0, FN_XOR), nextPc, 1'b1, dst, value);
                end
            endcase
            nextPc = nextPc + 32'd4;
        end
    endtask

    //////////////////////////////
    // compare tasks
    //////////////////////////////
    task automatic checkPc(input word_t expected, input string what);
        if (pc !== expected) begin
            $display("mismatch at %0t: %s pc is %h, expected %h", $time, what, pc, expected);
            stepErrors++;
        end
    endtask

    task automatic checkWb(input logic expEn, input regIdx_t expReg, input word_t expData,
                           input string what);
        if (wbEn !== expEn) begin
            $display("mismatch at %0t: %s wbEn is %b, expected %b", $time, what, wbEn, expEn);
            stepErrors++;
        end else if (expEn && (wbReg !== expReg || wbData !== expData)) begin
            $display("mismatch at %0t: %s wrote r%0d=%h, expected r%0d=%h", $time, what,
                     wbReg, wbData, expReg, expData);
            stepErrors++;
        end
    endtask

    task automatic closeStep(input int idx, input string what);
        if (stepErrors == 0) begin
            $display("step %0d %s pc=%h ok", idx, what, pc);
            passCount++;
        end else begin
            $display("step %0d %s pc=%h failed", idx, what, pc);
            failCount++;
        end
        stepErrors = 0;
    endtask

    initial begin : watchdog
        wait (tableBuilt);
        #((tabInstr.size() + resetCycles + marginCycles) * clkPeriod);
        $display("timeout: the program table did not finish in the expected time");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        rst = 1'b1;
        instr = iType(OP_ADDI, 5'd0, 5'd1, 16'h0001);           // a writing instruction held off
        buildTable();
        tableBuilt = 1'b1;
        repeat (resetCycles - 1) @(negedge clk);
        #5;
        checkPc(resetPc, "reset");
        checkWb(1'b0, 5'd0, 32'h0, "reset");
        closeStep(0, "reset");
        @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < tabInstr.size(); i++) begin
            instr = tabInstr[i];
            #5;                                                  // outputs settle
            checkPc(tabPc[i], tabName[i]);
            checkWb(tabEn[i], tabReg[i], tabData[i], tabName[i]);
            closeStep(i + 1, tabName[i]);
            @(negedge clk);
        end
        $display("steps passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verification/TbClock.sv
`timescale 1ns/1ps
`default_nettype none

module TbClock (
    output logic clk
);

    localparam int halfPeriod = 20;                              // 40 ns period

    initial begin
        clk = 1'b0;
    end

    always #halfPeriod clk = ~clk;

endmodule

`default_nettype wire
